// ==== include/ising_params.svh ====
//********************
// Array size, weight level and delay stage macros
// Register bus address width
//********************

`ifndef ISING_PARAMS_SVH
`define ISING_PARAMS_SVH

// Spins, also rows and columns of the array
`define ISING_N 4

// Weight levels, odd so the midpoint is neutral coupling
`define ISING_NUM_WEIGHTS 15

// Delay elements per tap stage
`define ISING_NUM_LUTS 2

// Simulation delay of one element in ns
`define ISING_STAGE_DELAY 1

`define ISING_WEIGHT_W ($clog2(`ISING_NUM_WEIGHTS))
// Row in upper half, column in lower half
`define ISING_ADDR_W (2 * $clog2(`ISING_N))

`endif

// ==== rtl/ising_pkg.sv ====
//********************
// Array-side types
// Weights, spin vectors, cell indices
//********************

`include "ising_params.svh"

package ising_pkg;

    // One coupling level
    // Midpoint of the range is neutral coupling
    typedef logic [`ISING_WEIGHT_W-1:0] weight_t;

    // One phase per spin
    // Bit r is the ring node of row r
    typedef logic [`ISING_N-1:0] spin_vec_t;

    // Row or column number of the array
    typedef logic [$clog2(`ISING_N)-1:0] cell_index_t;

endpackage

// ==== rtl/weight_bus_pkg.sv ====
//********************
// Register bus types
// Write and read requests, read response
//********************

`include "ising_params.svh"

package weight_bus_pkg;

    import ising_pkg::*;

    // Cell address, row in upper half and column in lower half
    typedef logic [`ISING_ADDR_W-1:0] cell_addr_t;

    // Write strobe, weight loads on the same edge
    typedef struct packed {
        logic       valid;
        cell_addr_t addr;
        weight_t    data;
    } wr_req_t;

    // Read strobe
    typedef struct packed {
        logic       valid;
        cell_addr_t addr;
    } rd_req_t;

    // Read response, valid for one cycle
    typedef struct packed {
        logic    valid;
        weight_t data;
    } rd_rsp_t;

endpackage

// ==== rtl/delay_line.sv ====
//********************
// Tapped chain of behavioral delay stages
//********************

`timescale 1ns/1ps

`include "ising_params.svh"

module delay_line #(
    parameter int num_taps       = 15,
    parameter int luts_per_stage = 2
) (
    input  logic                phase_in,
    output logic [num_taps-1:0] taps
);

    // Flat chain of every element, node 0 is the line input
    logic [num_taps*luts_per_stage:0] chain;

    assign chain[0] = phase_in;

    // One stage per tap
    // Tap i sits after stage i, so tap 0 already has one stage of delay
    for (genvar s = 0; s < num_taps; s++) begin : g_stage
        for (genvar l = 0; l < luts_per_stage; l++) begin : g_elem
            localparam int node = s * luts_per_stage + l;

            // Behavioral element
            // Stands in for one LUT buffer on the real fabric
            assign #(`ISING_STAGE_DELAY) chain[node+1] = chain[node];
        end

        // Stage output
        assign taps[s] = chain[(s+1)*luts_per_stage];
    end

    // Total line length is num_taps * luts_per_stage elements
    // Longest tap adds num_taps stages to the row
    // Shortest tap adds a single stage

    // Pulses shorter than one element are swallowed by the
    // inertial delay, far below any ring half period

endmodule

// ==== rtl/coupled_cell.sv ====
//********************
// One coupling cell of the array
// Weight register, source sampling, tap selection
//********************

`timescale 1ns/1ps

`include "ising_params.svh"

module coupled_cell
    import ising_pkg::*;
(
    input  logic    clk,
    input  logic    din,
    input  logic    anneal_en,
    // Asynchronous phase path
    input  logic    phase_in,
    input  logic    source_phase,
    output logic    phase_out,
    // Register side
    input  logic    wr_en,
    input  weight_t wr_data,
    output weight_t weight
);

    localparam int      num_weights = `ISING_NUM_WEIGHTS;
    // Neutral coupling, both taps equal
    localparam weight_t weight_mid  = weight_t'(num_weights / 2);

    weight_t                weight_q;
    logic [num_weights-1:0] weight_oh;
    logic                   source_samp;
    logic                   mismatch;
    logic [num_weights-1:0] taps;
    logic [num_weights-1:0] sel_mismatch;
    logic [num_weights-1:0] sel_match;

    // Weight register
    always_ff @(posedge clk or negedge din) begin
        if (!din) begin
            weight_q <= weight_mid;
        end else if (wr_en) begin
            weight_q <= wr_data;
        end
    end

    assign weight = weight_q;

    // One-hot weight
    for (genvar i = 0; i < num_weights; i++) begin : g_oh
        assign weight_oh[i] = (weight_q == weight_t'(i));
    end

    // Source phase taken on every edge of our own phase
    // Breaks the loop through other rows and keeps the select stable
    // for the whole half period
    always_ff @(posedge phase_in or negedge phase_in or negedge anneal_en) begin
        if (!anneal_en) begin
            source_samp <= 1'b0;
        end else begin
            source_samp <= source_phase;
        end
    end

    assign mismatch = phase_in ^ source_samp;

    delay_line #(
        .num_taps      (num_weights),
        .luts_per_stage(`ISING_NUM_LUTS)
    ) i_delay_line (
        .phase_in(phase_in),
        .taps    (taps)
    );

    // Mismatch picks tap weight, match picks the mirrored tap
    // High weight slows the row on mismatch and speeds it on match
    for (genvar i = 0; i < num_weights; i++) begin : g_sel
        assign sel_mismatch[i] = weight_oh[i] & taps[i];
        assign sel_match[i]    = weight_oh[num_weights-1-i] & taps[i];
    end

    assign phase_out = mismatch ? (|sel_mismatch) : (|sel_match);

endmodule

// ==== rtl/spin_oscillator.sv ====
//********************
// One spin, a row of coupled cells
// closed into a gated inverting ring
//********************

`timescale 1ns/1ps

`include "ising_params.svh"

module spin_oscillator
    import ising_pkg::*;
(
    input  logic                clk,
    input  logic                din,
    input  logic                anneal_en,
    // Phases of all spins, column sources
    input  spin_vec_t           source_phases,
    output logic                spin,
    // Register side, one strobe per column
    input  logic [`ISING_N-1:0] wr_en,
    input  weight_t             wr_data,
    output weight_t             weights [`ISING_N]
);

    // Ring node, drives cell 0
    logic                ring_node;
    // Phase between cells, node c feeds cell c
    logic [`ISING_N:0]   row_phase;

    assign row_phase[0] = ring_node;

    // Cells of the row in a chain
    // Each cell compares against the spin of its column
    for (genvar c = 0; c < `ISING_N; c++) begin : g_cell
        coupled_cell i_cell (
            .clk         (clk),
            .din         (din),
            .anneal_en   (anneal_en),
            .phase_in    (row_phase[c]),
            .source_phase(source_phases[c]),
            .phase_out   (row_phase[c+1]),
            .wr_en       (wr_en[c]),
            .wr_data     (wr_data),
            .weight      (weights[c])
        );
    end

    // Ring gate
    // Inverts the last cell while annealing
    // Held low otherwise so the whole row drains to zero
    assign ring_node = anneal_en & ~row_phase[`ISING_N];

    // One full period is two trips around the row
    // At neutral weights each cell adds (mid+1) stages per trip

    // Ring node is the spin phase
    assign spin = ring_node;

endmodule

// ==== rtl/weight_bus_decoder.sv ====
//********************
// Register bus decoder
// Per-cell write strobes, registered read-back
//********************

`timescale 1ns/1ps

`include "ising_params.svh"

module weight_bus_decoder
    import ising_pkg::*;
    import weight_bus_pkg::*;
(
    input  logic                               clk,
    input  logic                               din,
    input  wr_req_t                            wr_req,
    input  rd_req_t                            rd_req,
    output rd_rsp_t                            rd_rsp,
    output logic [`ISING_N-1:0][`ISING_N-1:0]  cell_wr_en,
    output weight_t                            wr_data,
    input  weight_t                            cell_weights [`ISING_N][`ISING_N]
);

    localparam int idx_w = $clog2(`ISING_N);

    cell_index_t wr_row;
    cell_index_t wr_col;
    cell_index_t rd_row;
    cell_index_t rd_col;
    logic        wr_in_range;
    logic        rd_in_range;
    weight_t     rd_data_sel;
    logic        rd_valid_q;
    weight_t     rd_data_q;

    // Address split, row in upper half
    assign wr_row = wr_req.addr[`ISING_ADDR_W-1 -: idx_w];
    assign wr_col = wr_req.addr[idx_w-1:0];
    assign rd_row = rd_req.addr[`ISING_ADDR_W-1 -: idx_w];
    assign rd_col = rd_req.addr[idx_w-1:0];

    assign wr_in_range = (int'(wr_row) < `ISING_N) && (int'(wr_col) < `ISING_N);
    assign rd_in_range = (int'(rd_row) < `ISING_N) && (int'(rd_col) < `ISING_N);

    // One strobe for an in-range write, cell loads on this edge
    always_comb begin
        cell_wr_en = '0;
        if (wr_req.valid && wr_in_range) begin
            cell_wr_en[wr_row][wr_col] = 1'b1;
        end
    end

    // Shared write data
    assign wr_data = wr_req.data;

    // Read mux, zero outside the array
    assign rd_data_sel = rd_in_range ? cell_weights[rd_row][rd_col] : '0;

    // Response valid, one cycle per strobe
    always_ff @(posedge clk or negedge din) begin
        if (!din) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req.valid) begin
            rd_data_q <= rd_data_sel;
        end
    end

    assign rd_rsp = '{valid: rd_valid_q, data: rd_data_q};

endmodule

// ==== rtl/ising_array.sv ====
//********************
// Ising machine top
// Bus decoder and one spin oscillator per row
//********************

`timescale 1ns/1ps

`include "ising_params.svh"

module ising_array
    import ising_pkg::*;
    import weight_bus_pkg::*;
(
    input  logic      clk,
    input  logic      din,
    // Level, high while annealing
    input  logic      anneal_en,
    // Register bus
    input  wr_req_t   wr_req,
    input  rd_req_t   rd_req,
    output rd_rsp_t   rd_rsp,
    // Raw spin phases
    output spin_vec_t spins
);

    // Write strobes indexed [row][col]
    logic [`ISING_N-1:0][`ISING_N-1:0] cell_wr_en;
    weight_t                           wr_data;
    // Weight levels back from every cell
    weight_t                           cell_weights [`ISING_N][`ISING_N];

    weight_bus_decoder i_decoder (
        .clk         (clk),
        .din         (din),
        .wr_req      (wr_req),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp),
        .cell_wr_en  (cell_wr_en),
        .wr_data     (wr_data),
        .cell_weights(cell_weights)
    );

    // One ring per spin
    // Every row sees all spins as its column sources
    for (genvar r = 0; r < `ISING_N; r++) begin : g_row
        spin_oscillator i_spin (
            .clk          (clk),
            .din          (din),
            .anneal_en    (anneal_en),
            .source_phases(spins),
            .spin         (spins[r]),
            .wr_en        (cell_wr_en[r]),
            .wr_data      (wr_data),
            .weights      (cell_weights[r])
        );
    end

    // Cell (r,c) couples spin r to spin c
    // Diagonal cells see their own spin, a fixed self term

endmodule

// ==== testbench/tb_clock_gen.sv ====
//********************
// Testbench clock and reset
//********************

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic din
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset low for 10 cycles, released just after an edge
    initial begin
        din = 1'b0;
        repeat (10) @(posedge clk);
        #1 din = 1'b1;
    end

endmodule

// ==== testbench/tb_ising_array.sv ====
//********************
// Testbench for the Ising array
// Register bus checks, ring period measurement
//********************

`timescale 1ns/1ps

`include "ising_params.svh"

module tb_ising_array
    import ising_pkg::*;
    import weight_bus_pkg::*;
();

    localparam int  n           = `ISING_N;
    localparam int  num_weights = `ISING_NUM_WEIGHTS;
    localparam int  mid         = num_weights / 2;
    localparam int  idx_w       = $clog2(`ISING_N);
    // Two trips around the row, each cell at tap mid
    localparam real ring_period = 2.0 * n * (mid + 1) * `ISING_NUM_LUTS * `ISING_STAGE_DELAY;
    // Timeouts in clock cycles
    localparam int  rsp_timeout = 4;
    localparam int  osc_timeout = 200;

    logic      clk;
    logic      din;
    logic      anneal_en;
    wr_req_t   wr_req;
    rd_req_t   rd_req;
    rd_rsp_t   rd_rsp;
    spin_vec_t spins;

    integer    seed = 95927;
    int        mismatch_count = 0;
    int        timeout_count = 0;
    // Expected weight of every cell
    weight_t   model [n][n];
    // Last two rising edge times per spin
    realtime   rise_time [n][2];
    int        rise_count [n] = '{default: 0};
    spin_vec_t spins_prev = '0;

    tb_clock_gen i_clock_gen (
        .clk(clk),
        .din(din)
    );

    ising_array i_dut (
        .clk      (clk),
        .din      (din),
        .anneal_en(anneal_en),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .rd_rsp   (rd_rsp),
        .spins    (spins)
    );

    // Edge times straight from the raw spin levels
    always @(spins) begin
        for (int r = 0; r < n; r++) begin
            if (spins[r] && !spins_prev[r]) begin
                rise_time[r][0] = rise_time[r][1];
                rise_time[r][1] = $realtime;
                rise_count[r]++;
            end
        end
        spins_prev = spins;
    end

    // Response valid exactly one cycle after each strobe, low otherwise
    assert property (@(posedge clk) disable iff (!din) rd_rsp.valid == $past(rd_req.valid))
    else begin
        mismatch_count++;
        $display("mismatch at %0t: rd_rsp valid out of step with read strobe", $time);
    end

    // Gated rings drain to zero
    assert property (@(posedge clk) disable iff (!din) !anneal_en |-> spins == '0)
    else begin
        mismatch_count++;
        $display("mismatch at %0t: spins %b while anneal_en low", $time, $sampled(spins));
    end

    // Row in upper half, column in lower half
    function automatic int cell_addr(input int row, input int col);
        return (row << idx_w) | col;
    endfunction

    // All tasks start and end 1 ns after a rising edge
    task automatic write_addr(input int addr, input weight_t data);
        wr_req = '{valid: 1'b1, addr: cell_addr_t'(addr), data: data};
        @(posedge clk);
        #1;
        wr_req.valid = 1'b0;
    endtask

    task automatic read_addr(input int addr, output weight_t data);
        int waited;
        rd_req = '{valid: 1'b1, addr: cell_addr_t'(addr)};
        @(posedge clk);
        #1;
        rd_req.valid = 1'b0;
        waited = 0;
        while (!rd_rsp.valid && waited < rsp_timeout) begin
            @(posedge clk);
            #1;
            waited++;
        end
        data = rd_rsp.data;
        if (!rd_rsp.valid) begin
            timeout_count++;
            $display("timeout at %0t: no read response for address %0d", $time, addr);
        end
    endtask

    task automatic check_read(input int addr, input weight_t exp);
        weight_t got;
        read_addr(addr, got);
        assert (got == exp) else begin
            mismatch_count++;
            $display("mismatch at %0t: address %0d read %0d, expected %0d",
                     $time, addr, got, exp);
        end
    endtask

    task automatic check_all_cells();
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                check_read(cell_addr(r, c), model[r][c]);
            end
        end
    endtask

    task automatic wait_rises(input int r, input int target);
        int waited;
        waited = 0;
        while (rise_count[r] < target && waited < osc_timeout) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (rise_count[r] < target) begin
            timeout_count++;
            $display("timeout at %0t: spin %0d stopped toggling", $time, r);
        end
    endtask

    initial begin
        int      waited;
        int      row;
        int      col;
        int      start [n];
        real     diff;
        weight_t data;
        wr_req    = '0;
        rd_req    = '0;
        anneal_en = 1'b0;
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                model[r][c] = weight_t'(mid);
            end
        end
        waited = 0;
        while (!din && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (!din) begin
            timeout_count++;
            $display("timeout at %0t: reset never released", $time);
        end
        @(posedge clk);
        #1;

        // Reset value everywhere
        check_all_cells();

        // Random in-range writes against the model
        repeat (40) begin
            row  = $unsigned($random(seed)) % n;
            col  = $unsigned($random(seed)) % n;
            data = weight_t'($unsigned($random(seed)) % num_weights);
            write_addr(cell_addr(row, col), data);
            model[row][col] = data;
        end
        check_all_cells();

        // Addresses outside the array, if the address space has any
        for (int a = 0; a < (1 << `ISING_ADDR_W); a++) begin
            if ((a >> idx_w) >= n || (a % (1 << idx_w)) >= n) begin
                write_addr(a, weight_t'($unsigned($random(seed)) % num_weights));
                check_read(a, '0);
            end
        end
        check_all_cells();

        // Idle rings, concurrent check watches spins
        repeat (50) @(posedge clk);
        #1;

        // Neutral weights give the exact ring period
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                write_addr(cell_addr(r, c), weight_t'(mid));
                model[r][c] = weight_t'(mid);
            end
        end
        start = rise_count;
        anneal_en = 1'b1;
        for (int r = 0; r < n; r++) begin
            wait_rises(r, start[r] + 3);
            diff = (rise_time[r][1] - rise_time[r][0]) - ring_period;
            assert (diff < 0.001 && diff > -0.001) else begin
                mismatch_count++;
                $display("mismatch at %0t: spin %0d period %0.3f ns, expected %0.3f ns",
                         $time, r, rise_time[r][1] - rise_time[r][0], ring_period);
            end
        end
        anneal_en = 1'b0;
        // Let the delay lines drain
        repeat (20) @(posedge clk);
        #1;

        // Random couplings, rings must keep running
        for (int r = 0; r < n; r++) begin
            for (int c = 0; c < n; c++) begin
                data = weight_t'($unsigned($random(seed)) % num_weights);
                write_addr(cell_addr(r, c), data);
                model[r][c] = data;
            end
        end
        check_all_cells();
        start = rise_count;
        anneal_en = 1'b1;
        for (int r = 0; r < n; r++) begin
            wait_rises(r, start[r] + 2);
        end
        anneal_en = 1'b0;
        @(posedge clk);
        #1;
        assert (spins == '0) else begin
            mismatch_count++;
            $display("mismatch at %0t: spins %b after anneal_en dropped", $time, spins);
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== Bender.yml ====
package:
  name: ising_array

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/ising_pkg.sv
      - rtl/weight_bus_pkg.sv
      - rtl/delay_line.sv
      - rtl/coupled_cell.sv
      - rtl/spin_oscillator.sv
      - rtl/weight_bus_decoder.sv
      - rtl/ising_array.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_ising_array.sv

// ==== ising_array.f ====
+incdir+include
rtl/ising_pkg.sv
rtl/weight_bus_pkg.sv
rtl/delay_line.sv
rtl/coupled_cell.sv
rtl/spin_oscillator.sv
rtl/weight_bus_decoder.sv
rtl/ising_array.sv
testbench/tb_clock_gen.sv
testbench/tb_ising_array.sv
